/* logic/epu_pkg.sv */
/*
 Shared types and constants of the exception processing unit.
 Data path is 32 bits wide; program counters are word addresses (30 bits).
 MSR address: bank number in bits 15..12, one-hot offset in bits 8..0.
*/
package epu_pkg;

   localparam int DATA_W    = 32;
   localparam int PC_W      = DATA_W - 2;
   localparam int PSR_W     = 10;
   localparam int IRQ_W     = 32;
   localparam int BANK_W    = 4;
   localparam int BANK_LSB  = 12;
   localparam int OFF_W     = 9;
   localparam int TCR_CNT_W = 28;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [PC_W-1:0]   pc_t;
   typedef logic [IRQ_W-1:0]  irq_vec_t;
   typedef logic [BANK_W-1:0] bank_t;
   typedef logic [OFF_W-1:0]  bank_off_t;

   // Bank codes, anything else is unmapped
   localparam bank_t BANK_PS   = 4'd0;
   localparam bank_t BANK_IRQC = 4'd6;
   localparam bank_t BANK_TSC  = 4'd7;

   // Offset bits inside PS bank
   localparam int OFF_PSR    = 0;
   localparam int OFF_CPUID  = 1;
   localparam int OFF_EPSR   = 2;
   localparam int OFF_EPC    = 3;
   localparam int OFF_ELSA   = 4;
   localparam int OFF_COREID = 5;
   // IRQC bank
   localparam int OFF_IMR    = 0;
   localparam int OFF_IRR    = 1;
   // TSC bank
   localparam int OFF_TSR    = 0;
   localparam int OFF_TCR    = 1;

   // Word offsets from VECTOR_BASE
   localparam pc_t VOFF_EITM    = 30'd1;
   localparam pc_t VOFF_EIPF    = 30'd2;
   localparam pc_t VOFF_ESYSCALL = 30'd3;
   localparam pc_t VOFF_EINSN   = 30'd4;
   localparam pc_t VOFF_EIRQ    = 30'd5;
   localparam pc_t VOFF_EDTM    = 30'd6;
   localparam pc_t VOFF_EDPF    = 30'd7;
   localparam pc_t VOFF_EALIGN  = 30'd8;

   // TCR layout, compare value in the low bits
   localparam int TCR_EN = 28;
   localparam int TCR_I  = 29;
   localparam int TCR_P  = 30;

   typedef struct packed {
      logic [1:0] res_hi;
      logic       dmme;
      logic       imme;
      logic       ire;
      logic       rm;
      logic [3:0] res_lo;
   } psr_t;

   typedef struct packed {
      logic eret;
      logic esyscall;
      logic einsn;
      logic eipf;
      logic eitm;
      logic eirq;
      logic wmsr;
   } epu_op_t;

   // Exception strobes leaving execute
   typedef struct packed {
      logic eret;
      logic esyscall;
      logic einsn;
      logic eipf;
      logic eitm;
      logic eirq;
   } epu_exc_t;

   typedef struct packed {
      logic      psr;
      logic      epc;
      logic      epsr;
      logic      elsa;
      logic      imr;
      logic      tsr;
      logic      tcr;
      bank_off_t off;
   } msr_we_t;

   typedef struct packed {
      logic eret;
      logic esyscall;
      logic einsn;
      logic eipf;
      logic eitm;
      logic eirq;
      logic edtm;
      logic edpf;
      logic ealign;
   } exc_cause_t;

endpackage

/* logic/epu_top.sv */
/*
 Exception processing unit top level.
 PSR, EPSR, EPC and ELSA live outside; this unit drives next values and enables.
 IMR, TSR and TCR are written from the commit-side write record.
*/
`timescale 1ns/1ns

module epu_top import epu_pkg::*; #(
   parameter pc_t VECTOR_BASE = 30'h100,
   parameter int  NUM_IRQ     = 8
) (
   input  logic       clk,
   input  logic       rst,
   // Execute side
   input  logic       ex_valid,
   input  epu_op_t    ex_op,
   input  data_t      ex_operand1,
   input  data_t      ex_operand2,
   input  data_t      ex_imm,
   // Commit side
   input  exc_cause_t commit_cause,
   input  pc_t        commit_pc,
   input  pc_t        commit_npc,
   input  data_t      commit_lsa,
   input  msr_we_t    commit_wmsr_we,
   input  data_t      commit_wmsr_dat,
   input  irq_vec_t   irqs,
   // Current register values
   input  psr_t       msr_psr,
   input  psr_t       msr_psr_nold,
   input  psr_t       msr_epsr,
   input  data_t      msr_epc,
   input  data_t      msr_elsa,
   input  data_t      msr_cpuid,
   input  data_t      msr_coreid,
   output data_t      epu_dout,
   output msr_we_t    epu_wmsr_we,
   output data_t      epu_wmsr_dat,
   output epu_exc_t   epu_exc,
   output psr_t       psr_nxt,
   output logic       psr_we,
   output psr_t       epsr_nxt,
   output logic       epsr_we,
   output data_t      epc_nxt,
   output logic       epc_we,
   output data_t      elsa_nxt,
   output logic       elsa_we,
   output logic       exc_ent,
   output logic       exc_flush,
   output pc_t        exc_flush_tgt,
   output logic       irq_async,
   output logic       tsc_irq
);

   data_t imr;
   data_t irr;
   data_t tsr;
   data_t tcr;

   msr_read_decode u_decode (
      .ex_valid     (ex_valid),
      .ex_op        (ex_op),
      .ex_operand1  (ex_operand1),
      .ex_operand2  (ex_operand2),
      .ex_imm       (ex_imm),
      .msr_psr      (msr_psr),
      .msr_epsr     (msr_epsr),
      .msr_epc      (msr_epc),
      .msr_elsa     (msr_elsa),
      .msr_cpuid    (msr_cpuid),
      .msr_coreid   (msr_coreid),
      .imr          (imr),
      .irr          (irr),
      .tsr          (tsr),
      .tcr          (tcr),
      .epu_dout     (epu_dout),
      .epu_wmsr_we  (epu_wmsr_we),
      .epu_wmsr_dat (epu_wmsr_dat),
      .epu_exc      (epu_exc)
   );

   exc_commit #(
      .VECTOR_BASE (VECTOR_BASE)
   ) u_commit (
      .clk             (clk),
      .rst             (rst),
      .commit_cause    (commit_cause),
      .commit_pc       (commit_pc),
      .commit_npc      (commit_npc),
      .commit_lsa      (commit_lsa),
      .commit_wmsr_we  (commit_wmsr_we),
      .commit_wmsr_dat (commit_wmsr_dat),
      .msr_psr_nold    (msr_psr_nold),
      .msr_epsr        (msr_epsr),
      .msr_epc         (msr_epc),
      .psr_nxt         (psr_nxt),
      .psr_we          (psr_we),
      .epsr_nxt        (epsr_nxt),
      .epsr_we         (epsr_we),
      .epc_nxt         (epc_nxt),
      .epc_we          (epc_we),
      .elsa_nxt        (elsa_nxt),
      .elsa_we         (elsa_we),
      .exc_ent         (exc_ent),
      .exc_flush       (exc_flush),
      .exc_flush_tgt   (exc_flush_tgt)
   );

   irq_ctrl #(
      .NUM_IRQ (NUM_IRQ)
   ) u_irq (
      .clk       (clk),
      .rst       (rst),
      .irqs      (irqs),
      .psr_ire   (msr_psr.ire),
      .imr_we    (commit_wmsr_we.imr),
      .imr_nxt   (commit_wmsr_dat),
      .imr       (imr),
      .irr       (irr),
      .irq_async (irq_async)
   );

   tsc_timer u_tsc (
      .clk     (clk),
      .rst     (rst),
      .tsr_we  (commit_wmsr_we.tsr),
      .tcr_we  (commit_wmsr_we.tcr),
      .wdat    (commit_wmsr_dat),
      .tsr     (tsr),
      .tcr     (tcr),
      .tsc_irq (tsc_irq)
   );

endmodule

/* logic/exc_commit.sv */
/*
 Commit-side update of PSR, EPSR, EPC and ELSA plus the flush request.
 At most one commit cause is expected per cycle.
 PSR is saved into EPSR only on the first cycle of a held exception.
*/
`timescale 1ns/1ns

module exc_commit import epu_pkg::*; #(
   parameter pc_t VECTOR_BASE = 30'h100
) (
   input  logic       clk,
   input  logic       rst,
   input  exc_cause_t commit_cause,
   input  pc_t        commit_pc,
   input  pc_t        commit_npc,
   input  data_t      commit_lsa,
   input  msr_we_t    commit_wmsr_we,
   input  data_t      commit_wmsr_dat,
   input  psr_t       msr_psr_nold,
   input  psr_t       msr_epsr,
   input  data_t      msr_epc,
   output psr_t       psr_nxt,
   output logic       psr_we,
   output psr_t       epsr_nxt,
   output logic       epsr_we,
   output data_t      epc_nxt,
   output logic       epc_we,
   output data_t      elsa_nxt,
   output logic       elsa_we,
   output logic       exc_ent,
   output logic       exc_flush,
   output pc_t        exc_flush_tgt
);

   logic exc_any;
   logic exc_ent_q;
   logic save_psr;
   logic elsa_from_pc;
   logic elsa_from_lsa;
   psr_t wr_psr;
   pc_t  vec_off;

   assign exc_any = |commit_cause;
   assign exc_ent = exc_any & ~commit_cause.eret;

   // Low bits of the write data in PSR layout
   assign wr_psr = psr_t'(commit_wmsr_dat[PSR_W-1:0]);

   // eret restores the mode bits from EPSR
   assign psr_we  = commit_wmsr_we.psr | commit_cause.eret;
   assign psr_nxt = commit_wmsr_we.psr ? wr_psr : msr_epsr;

   // Rising edge of exception entry
   always_ff @(posedge clk) begin
      if (rst) begin
         exc_ent_q <= 1'b0;
      end else begin
         exc_ent_q <= exc_ent;
      end
   end

   assign save_psr = exc_ent & ~exc_ent_q;

   assign epsr_we  = commit_wmsr_we.epsr | save_psr;
   assign epsr_nxt = commit_wmsr_we.epsr ? wr_psr : msr_psr_nold;

   // Syscall returns past itself, other exceptions retry the faulting insn
   assign epc_we  = exc_ent | commit_wmsr_we.epc;
   assign epc_nxt = commit_wmsr_we.epc    ? commit_wmsr_dat :
                    commit_cause.esyscall ? {commit_npc, 2'b00} :
                                            {commit_pc, 2'b00};

   // Fetch-side faults report the PC, data-side faults the access address
   assign elsa_from_pc  = commit_cause.eitm | commit_cause.eipf | commit_cause.einsn;
   assign elsa_from_lsa = commit_cause.edtm | commit_cause.edpf | commit_cause.ealign;
   assign elsa_we  = elsa_from_pc | elsa_from_lsa | commit_wmsr_we.elsa;
   assign elsa_nxt = elsa_from_pc  ? {commit_pc, 2'b00} :
                     elsa_from_lsa ? commit_lsa :
                                     commit_wmsr_dat;

   // Vector offset of the active cause
   always_comb begin
      vec_off = '0;
      if (commit_cause.eitm) begin
         vec_off = VOFF_EITM;
      end else if (commit_cause.eipf) begin
         vec_off = VOFF_EIPF;
      end else if (commit_cause.esyscall) begin
         vec_off = VOFF_ESYSCALL;
      end else if (commit_cause.einsn) begin
         vec_off = VOFF_EINSN;
      end else if (commit_cause.eirq) begin
         vec_off = VOFF_EIRQ;
      end else if (commit_cause.edtm) begin
         vec_off = VOFF_EDTM;
      end else if (commit_cause.edpf) begin
         vec_off = VOFF_EDPF;
      end else if (commit_cause.ealign) begin
         vec_off = VOFF_EALIGN;
      end
   end

   assign exc_flush     = exc_any;
   assign exc_flush_tgt = commit_cause.eret ? msr_epc[DATA_W-1:2] : VECTOR_BASE + vec_off;

endmodule

/* logic/irq_ctrl.sv */
/*
 Interrupt mask register and request view.
 NUM_IRQ lines (1 to 32) are live; higher request bits always read zero.
*/
`timescale 1ns/1ns

module irq_ctrl import epu_pkg::*; #(
   parameter int NUM_IRQ = 8
) (
   input  logic     clk,
   input  logic     rst,
   input  irq_vec_t irqs,
   input  logic     psr_ire,
   input  logic     imr_we,
   input  data_t    imr_nxt,
   output data_t    imr,
   output data_t    irr,
   output logic     irq_async
);

   localparam irq_vec_t LIVE_MASK = irq_vec_t'((64'd1 << NUM_IRQ) - 64'd1);

   always_ff @(posedge clk) begin
      if (rst) begin
         imr <= '0;
      end else if (imr_we) begin
         imr <= imr_nxt;
      end
   end

   assign irr = irqs & imr & LIVE_MASK;

   // Level request, gated by the global enable in PSR
   assign irq_async = psr_ire & (|irr);

endmodule

/* logic/msr_read_decode.sv */
/*
 Execute-side MSR access, purely combinational.
 Unmapped banks and offsets read zero and never raise a write enable.
 All enables and strobes are qualified by ex_valid; the offset copy is not.
*/
`timescale 1ns/1ns

module msr_read_decode import epu_pkg::*; (
   input  logic     ex_valid,
   input  epu_op_t  ex_op,
   input  data_t    ex_operand1,
   input  data_t    ex_operand2,
   input  data_t    ex_imm,
   input  psr_t     msr_psr,
   input  psr_t     msr_epsr,
   input  data_t    msr_epc,
   input  data_t    msr_elsa,
   input  data_t    msr_cpuid,
   input  data_t    msr_coreid,
   input  data_t    imr,
   input  data_t    irr,
   input  data_t    tsr,
   input  data_t    tcr,
   output data_t    epu_dout,
   output msr_we_t  epu_wmsr_we,
   output data_t    epu_wmsr_dat,
   output epu_exc_t epu_exc
);

   data_t     msr_addr;
   bank_t     bank;
   bank_off_t off;
   logic      sel_ps;
   logic      sel_irqc;
   logic      sel_tsc;
   data_t     dout_ps;
   data_t     dout_irqc;
   data_t     dout_tsc;
   logic      wmsr_go;

   // Immediate only reaches the low 15 address bits
   assign msr_addr = ex_operand1 | {{(DATA_W-15){1'b0}}, ex_imm[14:0]};
   assign bank     = msr_addr[BANK_LSB +: BANK_W];
   assign off      = msr_addr[OFF_W-1:0];

   assign sel_ps   = (bank == BANK_PS);
   assign sel_irqc = (bank == BANK_IRQC);
   assign sel_tsc  = (bank == BANK_TSC);

   // Several offset bits may be set, the values are OR'ed
   assign dout_ps =
      ({DATA_W{off[OFF_PSR]}}    & {{(DATA_W-PSR_W){1'b0}}, msr_psr}) |
      ({DATA_W{off[OFF_CPUID]}}  & msr_cpuid) |
      ({DATA_W{off[OFF_EPSR]}}   & {{(DATA_W-PSR_W){1'b0}}, msr_epsr}) |
      ({DATA_W{off[OFF_EPC]}}    & msr_epc) |
      ({DATA_W{off[OFF_ELSA]}}   & msr_elsa) |
      ({DATA_W{off[OFF_COREID]}} & msr_coreid);

   assign dout_irqc = ({DATA_W{off[OFF_IMR]}} & imr) |
                      ({DATA_W{off[OFF_IRR]}} & irr);

   assign dout_tsc  = ({DATA_W{off[OFF_TSR]}} & tsr) |
                      ({DATA_W{off[OFF_TCR]}} & tcr);

   assign epu_dout = ({DATA_W{sel_ps}}   & dout_ps) |
                     ({DATA_W{sel_irqc}} & dout_irqc) |
                     ({DATA_W{sel_tsc}}  & dout_tsc);

   // Write enable record, applied later at commit
   assign wmsr_go      = ex_valid & ex_op.wmsr;
   assign epu_wmsr_dat = ex_operand2;

   assign epu_wmsr_we.psr  = wmsr_go & sel_ps & off[OFF_PSR];
   assign epu_wmsr_we.epc  = wmsr_go & sel_ps & off[OFF_EPC];
   assign epu_wmsr_we.epsr = wmsr_go & sel_ps & off[OFF_EPSR];
   assign epu_wmsr_we.elsa = wmsr_go & sel_ps & off[OFF_ELSA];
   assign epu_wmsr_we.imr  = wmsr_go & sel_irqc & off[OFF_IMR];
   assign epu_wmsr_we.tsr  = wmsr_go & sel_tsc & off[OFF_TSR];
   assign epu_wmsr_we.tcr  = wmsr_go & sel_tsc & off[OFF_TCR];
   assign epu_wmsr_we.off  = off;

   // Exception instruction strobes
   assign epu_exc.eret     = ex_valid & ex_op.eret;
   assign epu_exc.esyscall = ex_valid & ex_op.esyscall;
   assign epu_exc.einsn    = ex_valid & ex_op.einsn;
   assign epu_exc.eipf     = ex_valid & ex_op.eipf;
   assign epu_exc.eitm     = ex_valid & ex_op.eitm;
   assign epu_exc.eirq     = ex_valid & ex_op.eirq;

endmodule

/* logic/tsc_timer.sv */
/*
 Free-running timestamp counter with one compare register.
 Compare uses the low 28 bits of TSR, so it fires again after wrap.
 The pending bit stays set until software rewrites TCR.
*/
`timescale 1ns/1ns

module tsc_timer import epu_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  tsr_we,
   input  logic  tcr_we,
   input  data_t wdat,
   output data_t tsr,
   output data_t tcr,
   output logic  tsc_irq
);

   logic cnt_hit;

   assign cnt_hit = tcr[TCR_EN] & (tsr[TCR_CNT_W-1:0] == tcr[TCR_CNT_W-1:0]);

   // A write replaces the count instead of incrementing
   always_ff @(posedge clk) begin
      if (rst) begin
         tsr <= '0;
      end else if (tsr_we) begin
         tsr <= wdat;
      end else begin
         tsr <= tsr + data_t'(1);
      end
   end

   // Software write has priority over the compare
   always_ff @(posedge clk) begin
      if (rst) begin
         tcr <= '0;
      end else if (tcr_we) begin
         tcr <= wdat;
      end else if (cnt_hit) begin
         tcr[TCR_P] <= 1'b1;
      end
   end

   assign tsc_irq = tcr[TCR_I] & tcr[TCR_P];

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the epu testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module epu_tb -o epu_sim
./obj_dir/epu_sim > sim.log 2>&1
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
   exit 1
fi
exit 0

/* tb.f */
logic/epu_pkg.sv
logic/msr_read_decode.sv
logic/exc_commit.sv
logic/irq_ctrl.sv
logic/tsc_timer.sv
logic/epu_top.sv
verification/epu_assert.sv
verification/epu_tb.sv

/* verification/epu_assert.sv */
/*
 Concurrent checks on the commit side of the exception unit.
 Bound into every exc_commit instance; inactive while rst is high.
*/
`timescale 1ns/1ns

module epu_assert import epu_pkg::*; (
   input logic       clk,
   input logic       rst,
   input exc_cause_t commit_cause,
   input msr_we_t    commit_wmsr_we,
   input logic       epsr_we,
   input logic       exc_flush
);

   logic save_we;

   // EPSR write that comes from the save path only
   assign save_we = epsr_we & ~commit_wmsr_we.epsr;

   a_one_cause: assert property (@(posedge clk) disable iff (rst) $onehot0(commit_cause))
      else $error("more than one commit cause active");

   a_flush: assert property (@(posedge clk) disable iff (rst) exc_flush == (|commit_cause))
      else $error("exc_flush differs from the OR of the commit causes");

   a_save_once: assert property (@(posedge clk) disable iff (rst) save_we |=> !save_we)
      else $error("PSR saved into EPSR on two consecutive cycles");

endmodule

bind exc_commit epu_assert u_assert (
   .clk            (clk),
   .rst            (rst),
   .commit_cause   (commit_cause),
   .commit_wmsr_we (commit_wmsr_we),
   .epsr_we        (epsr_we),
   .exc_flush      (exc_flush)
);

/* verification/epu_tb.sv */
/*
 Testbench for epu_top with VECTOR_BASE 0x100 and 8 live interrupt lines.
 IMR, TSR, TCR and the exception entry flop are modeled from the driven inputs.
 Outputs are compared on the falling edge, inputs change on the rising edge.
*/
`timescale 1ns/1ns

module epu_tb import epu_pkg::*; ();

   localparam pc_t     VBASE     = 30'h100;
   localparam int      NIRQ      = 8;
   localparam data_t   LIVE      = 32'h0000_00ff;
   localparam int      MAX_CYCLE = 2000;

   typedef struct packed {
      logic  psr_we;
      psr_t  psr;
      logic  epsr_we;
      psr_t  epsr;
      logic  epc_we;
      data_t epc;
      logic  elsa_we;
      data_t elsa;
      logic  ent;
      logic  flush;
      pc_t   tgt;
   } commit_exp_t;

   logic clk;
   logic rst;
   logic ex_valid;
   epu_op_t ex_op;
   data_t ex_operand1, ex_operand2, ex_imm;
   exc_cause_t commit_cause;
   pc_t commit_pc, commit_npc;
   data_t commit_lsa, commit_wmsr_dat;
   msr_we_t commit_wmsr_we;
   irq_vec_t irqs;
   psr_t msr_psr, msr_psr_nold, msr_epsr;
   data_t msr_epc, msr_elsa, msr_cpuid, msr_coreid;
   data_t epu_dout, epu_wmsr_dat, epc_nxt, elsa_nxt;
   msr_we_t epu_wmsr_we;
   epu_exc_t epu_exc;
   psr_t psr_nxt, epsr_nxt;
   logic psr_we, epsr_we, epc_we, elsa_we, exc_ent, exc_flush, irq_async, tsc_irq;
   pc_t exc_flush_tgt;

   // Reference state
   data_t m_imr, m_tsr, m_tcr;
   logic  m_ent_q;
   logic [31:0] lfsr;
   int errors;
   int cycles;

   epu_top #(.VECTOR_BASE(VBASE), .NUM_IRQ(NIRQ)) DUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Galois LFSR, one step per bit taken
   function automatic data_t rand_bits(input int n);
      data_t r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic data_t ref_read(input data_t addr, input data_t irr);
      data_t v;
      logic [8:0] o;
      v = '0;
      o = addr[8:0];
      case (addr[15:12])
         4'd0: begin
            if (o[0]) v |= {22'd0, msr_psr};
            if (o[1]) v |= msr_cpuid;
            if (o[2]) v |= {22'd0, msr_epsr};
            if (o[3]) v |= msr_epc;
            if (o[4]) v |= msr_elsa;
            if (o[5]) v |= msr_coreid;
         end
         4'd6: v = (o[0] ? m_imr : '0) | (o[1] ? irr : '0);
         4'd7: v = (o[0] ? m_tsr : '0) | (o[1] ? m_tcr : '0);
         default: v = '0;
      endcase
      return v;
   endfunction

   function automatic msr_we_t ref_we(input logic go, input data_t addr);
      msr_we_t w;
      logic ps, ic, ts;
      ps = go && addr[15:12] == 4'd0;
      ic = go && addr[15:12] == 4'd6;
      ts = go && addr[15:12] == 4'd7;
      w.psr  = ps & addr[0];
      w.epc  = ps & addr[3];
      w.epsr = ps & addr[2];
      w.elsa = ps & addr[4];
      w.imr  = ic & addr[0];
      w.tsr  = ts & addr[0];
      w.tcr  = ts & addr[1];
      w.off  = addr[8:0];
      return w;
   endfunction

   function automatic commit_exp_t ref_commit(input exc_cause_t c, input logic first);
      commit_exp_t e;
      logic ent, from_pc, from_lsa;
      pc_t off;
      ent = (|c) & ~c.eret;
      from_pc = c.eitm | c.eipf | c.einsn;
      from_lsa = c.edtm | c.edpf | c.ealign;
      e.psr_we  = commit_wmsr_we.psr | c.eret;
      e.psr     = commit_wmsr_we.psr ? psr_t'(commit_wmsr_dat[9:0]) : msr_epsr;
      e.epsr_we = commit_wmsr_we.epsr | (ent & first);
      e.epsr    = commit_wmsr_we.epsr ? psr_t'(commit_wmsr_dat[9:0]) : msr_psr_nold;
      e.epc_we  = ent | commit_wmsr_we.epc;
      e.epc     = commit_wmsr_we.epc ? commit_wmsr_dat :
                  c.esyscall ? {commit_npc, 2'b00} : {commit_pc, 2'b00};
      e.elsa_we = from_pc | from_lsa | commit_wmsr_we.elsa;
      e.elsa    = from_pc ? {commit_pc, 2'b00} : from_lsa ? commit_lsa : commit_wmsr_dat;
      off = c.eitm ? 30'd1 : c.eipf ? 30'd2 : c.esyscall ? 30'd3 : c.einsn ? 30'd4 :
            c.eirq ? 30'd5 : c.edtm ? 30'd6 : c.edpf ? 30'd7 : c.ealign ? 30'd8 : 30'd0;
      e.ent     = ent;
      e.flush   = |c;
      e.tgt     = c.eret ? msr_epc[31:2] : VBASE + off;
      return e;
   endfunction

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
         errors++;
      end
   endtask

   // Models of the registers, updated from the same inputs as the DUT
   always @(posedge clk) begin
      if (rst) begin
         m_imr <= '0;
         m_tsr <= '0;
         m_tcr <= '0;
         m_ent_q <= 1'b0;
      end else begin
         m_ent_q <= (|commit_cause) & ~commit_cause.eret;
         if (commit_wmsr_we.imr) m_imr <= commit_wmsr_dat;
         m_tsr <= commit_wmsr_we.tsr ? commit_wmsr_dat : m_tsr + 1;
         if (commit_wmsr_we.tcr) m_tcr <= commit_wmsr_dat;
         else if (m_tcr[28] && m_tsr[27:0] == m_tcr[27:0]) m_tcr[30] <= 1'b1;
      end
   end

   always @(negedge clk) begin
      data_t addr, irr;
      commit_exp_t e;
      if (!rst) begin
         addr = ex_operand1 | {17'd0, ex_imm[14:0]};
         irr  = irqs & m_imr & LIVE;
         e    = ref_commit(commit_cause, ~m_ent_q);
         check("epu_dout", ref_read(addr, irr), epu_dout);
         check("epu_wmsr_we", ref_we(ex_valid & ex_op.wmsr, addr), epu_wmsr_we);
         check("epu_wmsr_dat", ex_operand2, epu_wmsr_dat);
         check("epu_exc", ex_op[6:1] & {6{ex_valid}}, epu_exc);
         check("psr_we", e.psr_we, psr_we);
         if (e.psr_we) check("psr_nxt", e.psr, psr_nxt);
         check("epsr_we", e.epsr_we, epsr_we);
         if (e.epsr_we) check("epsr_nxt", e.epsr, epsr_nxt);
         check("epc_we", e.epc_we, epc_we);
         if (e.epc_we) check("epc_nxt", e.epc, epc_nxt);
         check("elsa_we", e.elsa_we, elsa_we);
         if (e.elsa_we) check("elsa_nxt", e.elsa, elsa_nxt);
         check("exc_ent", e.ent, exc_ent);
         check("exc_flush", e.flush, exc_flush);
         if (e.flush) check("exc_flush_tgt", e.tgt, exc_flush_tgt);
         check("irq_async", msr_psr.ire & (|irr), irq_async);
         check("tsc_irq", m_tcr[29] & m_tcr[30], tsc_irq);
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLE) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLE);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   task automatic random_regs();
      msr_psr      <= psr_t'(rand_bits(10));
      msr_psr_nold <= psr_t'(rand_bits(10));
      msr_epsr     <= psr_t'(rand_bits(10));
      msr_epc      <= rand_bits(32);
      msr_elsa     <= rand_bits(32);
      msr_cpuid    <= rand_bits(32);
      msr_coreid   <= rand_bits(32);
      irqs         <= rand_bits(32);
   endtask

   task automatic commit_write(input msr_we_t we, input data_t dat);
      @(posedge clk);
      commit_wmsr_we  <= we;
      commit_wmsr_dat <= dat;
      @(posedge clk);
      commit_wmsr_we  <= '0;
   endtask

   initial begin
      logic [3:0] bank;
      data_t t1, t2, addr;
      msr_we_t we;
      bit seen;
      lfsr = 32'd37;
      errors = 0;
      cycles = 0;
      rst = 1'b1;
      ex_valid = 1'b0;
      ex_op = '0;
      ex_operand1 = '0;
      ex_operand2 = '0;
      ex_imm = '0;
      commit_cause = '0;
      commit_pc = '0;
      commit_npc = '0;
      commit_lsa = '0;
      commit_wmsr_we = '0;
      commit_wmsr_dat = '0;
      irqs = '0;
      msr_psr = '0;
      msr_psr_nold = '0;
      msr_epsr = '0;
      msr_epc = '0;
      msr_elsa = '0;
      msr_cpuid = '0;
      msr_coreid = '0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      // Random execute-side reads and write records over mapped and unmapped banks
      for (int i = 0; i < 200; i++) begin
         @(posedge clk);
         random_regs();
         case (rand_bits(2))
            0: bank = 4'd0;
            1: bank = 4'd6;
            2: bank = 4'd7;
            default: bank = 4'(rand_bits(4));
         endcase
         addr = {16'(rand_bits(16)), bank, 3'd0, 9'(rand_bits(9))};
         t1 = rand_bits(32);
         ex_operand1 <= addr & t1;
         ex_imm      <= {17'(rand_bits(17)), addr[14:0] & ~t1[14:0]};
         ex_operand2 <= rand_bits(32);
         ex_valid    <= 1'(rand_bits(1));
         ex_op       <= epu_op_t'(rand_bits(7));
      end
      @(posedge clk);
      ex_valid <= 1'b0;

      // Each single cause for one cycle, plus random PS writes at commit
      for (int i = 0; i < 9; i++) begin
         @(posedge clk);
         random_regs();
         commit_cause <= exc_cause_t'(9'b1 << i);
         commit_pc    <= pc_t'(rand_bits(30));
         commit_npc   <= pc_t'(rand_bits(30));
         commit_lsa   <= rand_bits(32);
         @(posedge clk);
         commit_cause <= '0;
         we = '0;
         {we.psr, we.epc, we.epsr, we.elsa} = 4'(rand_bits(4));
         commit_wmsr_we  <= we;
         commit_wmsr_dat <= rand_bits(32);
         @(posedge clk);
         commit_wmsr_we <= '0;
      end

      // Syscall held for three cycles saves PSR once
      for (int k = 0; k < 3; k++) begin
         @(posedge clk);
         commit_cause.esyscall <= 1'b1;
         @(negedge clk);
         check("held epsr_we", k == 0, epsr_we);
         check("held epc_we", 1'b1, epc_we);
      end
      @(posedge clk);
      commit_cause <= '0;

      // IMR write and request view through the IRR read
      we = '0;
      we.imr = 1'b1;
      commit_write(we, rand_bits(32));
      @(posedge clk);
      ex_operand1 <= 32'h0000_6002;
      ex_imm      <= '0;
      random_regs();
      @(negedge clk);
      check("irr", irqs & m_imr & LIVE, epu_dout);

      // TSR write, then two reads five cycles apart
      we = '0;
      we.tsr = 1'b1;
      commit_write(we, 32'h0000_1000);
      @(posedge clk);
      ex_operand1 <= 32'h0000_7001;
      @(negedge clk);
      t1 = epu_dout;
      repeat (5) @(posedge clk);
      @(negedge clk);
      t2 = epu_dout;
      check("tsr delta", 32'd5, t2 - t1);

      // Compare interrupt, then cleared by a TCR write with P low
      we = '0;
      we.tcr = 1'b1;
      commit_write(we, (32'h3 << 28) | ((m_tsr + 32'd20) & 32'h0fff_ffff));
      seen = 1'b0;
      for (int k = 0; k < 60 && !seen; k++) begin
         @(negedge clk);
         seen = tsc_irq;
      end
      if (!seen) begin
         $display("tsc_irq did not rise after the counter reached the compare value");
         errors++;
      end
      commit_write(we, (32'h3 << 28) | ((m_tsr - 32'd50) & 32'h0fff_ffff));
      @(negedge clk);
      check("tsc_irq cleared", 1'b0, tsc_irq);
      repeat (3) @(posedge clk);

      $display("Run complete with %0d errors", errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule
